/* common/rv_pkg.sv */
package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    op     = 7'b011_0011,
    op_imm = 7'b001_0011,
    load   = 7'b000_0011,
    store  = 7'b010_0011,
    branch = 7'b110_0011,
    jal    = 7'b110_1111,
    jalr   = 7'b110_0111,
    lui    = 7'b011_0111,
    auipc  = 7'b001_0111,
    system = 7'b111_0011
  } opcode_e;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]            imm_hi;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_lo;
    logic [6:0]            opcode;
  } s_fmt_t;

  typedef struct packed {
    logic                  imm_12;
    logic [5:0]            imm_10_5;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [3:0]            imm_4_1;
    logic                  imm_11;
    logic [6:0]            opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0]           imm;     // inst[31:12]
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } u_fmt_t;

  typedef struct packed {
    logic                  imm_20;
    logic [9:0]            imm_10_1;
    logic                  imm_11;
    logic [7:0]            imm_19_12;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } j_fmt_t;

  // one fetched word, six ways to read it
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_xor, alu_or, alu_and,
    alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu
  } alu_op_e;

  typedef enum logic [2:0] {
    wb_alu,
    wb_mem,
    wb_link,      // pc + 4
    wb_imm,       // lui
    wb_pc_target  // auipc
  } wb_sel_e;

  typedef struct packed {
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  reg_write;
    logic                  mem_read;
    logic                  mem_write;
    logic [2:0]            mem_size;    // funct3 of load/store
    logic                  is_branch;
    logic [2:0]            branch_cond; // funct3 of branch
    logic                  is_jal;
    logic                  is_jalr;
    wb_sel_e               wb_sel;
    logic                  halt;
    logic [xlen-1:0]       imm;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
  } ctrl_t;

  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [3:0]      wmask;
    logic            read;
    logic            write;
  } dmem_req_t;

endpackage

/* core/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
  input  rv_pkg::inst_t inst,
  output rv_pkg::ctrl_t ctrl
);

  logic [rv_pkg::xlen-1:0] imm_i;
  logic [rv_pkg::xlen-1:0] imm_s;
  logic [rv_pkg::xlen-1:0] imm_b;
  logic [rv_pkg::xlen-1:0] imm_u;
  logic [rv_pkg::xlen-1:0] imm_j;

  // funct3 plus funct7[5] to an alu operation
  function automatic rv_pkg::alu_op_e alu_decode(input logic [2:0] funct3,
                                                 input logic       alt,
                                                 input logic       is_reg);
    case (funct3)
      3'b000:  alu_decode = (is_reg && alt) ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  alu_decode = rv_pkg::alu_sll;
      3'b010:  alu_decode = rv_pkg::alu_slt;
      3'b011:  alu_decode = rv_pkg::alu_sltu;
      3'b100:  alu_decode = rv_pkg::alu_xor;
      3'b101:  alu_decode = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl; // srai too
      3'b110:  alu_decode = rv_pkg::alu_or;
      default: alu_decode = rv_pkg::alu_and;
    endcase
  endfunction

  assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_b = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                  inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
  assign imm_u = {inst.u.imm, 12'h000};
  assign imm_j = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                  inst.j.imm_11, inst.j.imm_10_1, 1'b0};

  always_comb begin
    ctrl             = '0;  // unknown opcode falls through as a nop
    ctrl.alu_op      = rv_pkg::alu_add;
    ctrl.wb_sel      = rv_pkg::wb_alu;
    ctrl.rd          = inst.r.rd;
    ctrl.rs1         = inst.r.rs1;
    ctrl.rs2         = inst.r.rs2;
    ctrl.mem_size    = inst.r.funct3;
    ctrl.branch_cond = inst.r.funct3;

    case (inst.r.opcode)
      rv_pkg::op: begin
        ctrl.alu_op    = alu_decode(inst.r.funct3, inst.r.funct7[5], 1'b1);
        ctrl.reg_write = 1'b1;
      end
      rv_pkg::op_imm: begin
        ctrl.alu_op    = alu_decode(inst.r.funct3, inst.r.funct7[5], 1'b0);
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.imm       = imm_i;
      end
      rv_pkg::load: begin
        ctrl.use_imm   = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = rv_pkg::wb_mem;
        ctrl.imm       = imm_i;
      end
      rv_pkg::store: begin
        ctrl.use_imm   = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.imm       = imm_s;
      end
      rv_pkg::branch: begin
        ctrl.alu_op    = rv_pkg::alu_sub; // compare rs1 against rs2
        ctrl.is_branch = 1'b1;
        ctrl.imm       = imm_b;
      end
      rv_pkg::jal: begin
        ctrl.is_jal    = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = rv_pkg::wb_link;
        ctrl.imm       = imm_j;
      end
      rv_pkg::jalr: begin
        ctrl.is_jalr   = 1'b1;
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = rv_pkg::wb_link;
        ctrl.imm       = imm_i;
      end
      rv_pkg::lui: begin
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = rv_pkg::wb_imm;
        ctrl.imm       = imm_u;
      end
      rv_pkg::auipc: begin
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = rv_pkg::wb_pc_target;
        ctrl.imm       = imm_u;
      end
      rv_pkg::system: begin
        // only ebreak matters, ecall and csr ops do nothing
        ctrl.halt = (inst.i.funct3 == 3'b000) && (inst.i.imm == 12'h001);
      end
      default: ;
    endcase
  end

endmodule

/* core/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2,
  output logic [rv_pkg::xlen-1:0]       rs1_data,
  output logic [rv_pkg::xlen-1:0]       rs2_data,
  input  logic                          we,
  input  logic [rv_pkg::reg_addr_w-1:0] rd,
  input  logic [rv_pkg::xlen-1:0]       wdata
);

  logic [rv_pkg::xlen-1:0] regs [0:31]; // x0 cleared on reset, never written

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

  // combinational read ports
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // a write aimed at x0 must not show up on a later read
  a_x0_reads_zero: assert property (
    @(posedge clk) disable iff (!arst_n)
    ((rs1 != '0) || (rs1_data == '0)) && ((rs2 != '0) || (rs2_data == '0))
  );

endmodule

/* core/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::ctrl_t           ctrl,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  output logic [rv_pkg::xlen-1:0] result,
  output logic                    take_branch
);

  logic [rv_pkg::xlen-1:0] op_a;
  logic [rv_pkg::xlen-1:0] op_b;
  logic [rv_pkg::xlen:0]   sub_full;  // carry out on top
  logic [rv_pkg::xlen-1:0] diff;
  logic                    carry;
  logic                    overflow;
  logic                    is_eq;
  logic                    is_lt;
  logic                    is_ltu;
  logic [4:0]              shamt;
  logic                    cond_met;

  assign op_a = rs1_data;
  assign op_b = ctrl.use_imm ? ctrl.imm : rs2_data;

  // single subtractor, a + ~b + 1
  assign sub_full = {1'b0, op_a} + {1'b0, ~op_b} + {{rv_pkg::xlen{1'b0}}, 1'b1};
  assign diff     = sub_full[rv_pkg::xlen-1:0];
  assign carry    = sub_full[rv_pkg::xlen];

  assign overflow = (op_a[rv_pkg::xlen-1] != op_b[rv_pkg::xlen-1]) &&
                    (diff[rv_pkg::xlen-1] != op_a[rv_pkg::xlen-1]);
  assign is_eq    = (diff == '0);
  assign is_lt    = diff[rv_pkg::xlen-1] ^ overflow;
  assign is_ltu   = ~carry;             // borrow means a < b

  assign shamt = op_b[4:0];

  always_comb begin
    case (ctrl.alu_op)
      rv_pkg::alu_add:  result = op_a + op_b;
      rv_pkg::alu_sub:  result = diff;
      rv_pkg::alu_xor:  result = op_a ^ op_b;
      rv_pkg::alu_or:   result = op_a | op_b;
      rv_pkg::alu_and:  result = op_a & op_b;
      rv_pkg::alu_sll:  result = op_a << shamt;
      rv_pkg::alu_srl:  result = op_a >> shamt;
      rv_pkg::alu_sra:  result = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::alu_slt:  result = {{(rv_pkg::xlen-1){1'b0}}, is_lt};
      rv_pkg::alu_sltu: result = {{(rv_pkg::xlen-1){1'b0}}, is_ltu};
      default:          result = '0;
    endcase
  end

  // branch condition by funct3
  always_comb begin
    case (ctrl.branch_cond)
      3'b000:  cond_met = is_eq;   // beq
      3'b001:  cond_met = ~is_eq;  // bne
      3'b100:  cond_met = is_lt;   // blt
      3'b101:  cond_met = ~is_lt;  // bge
      3'b110:  cond_met = is_ltu;  // bltu
      3'b111:  cond_met = ~is_ltu; // bgeu
      default: cond_met = 1'b0;
    endcase
  end

  assign take_branch = ctrl.is_branch && cond_met;

endmodule

/* core/rv_lsu.sv */
`timescale 1ns/1ps

module rv_lsu (
  input  rv_pkg::ctrl_t           ctrl,
  input  logic [rv_pkg::xlen-1:0] addr,
  input  logic [rv_pkg::xlen-1:0] store_data,
  output rv_pkg::dmem_req_t       dmem_req,
  input  logic [rv_pkg::xlen-1:0] dmem_rdata,
  output logic [rv_pkg::xlen-1:0] load_data
);

  logic [1:0]              offset;
  logic [3:0]              lane_mask;
  logic [rv_pkg::xlen-1:0] lane_word;  // addressed lane moved to bit 0

  assign offset = addr[1:0];

  // misaligned sizes leave the mask empty
  always_comb begin
    case (ctrl.mem_size[1:0])
      2'b00:   lane_mask = 4'b0001 << offset;
      2'b01:   lane_mask = offset[0] ? 4'b0000 : (offset[1] ? 4'b1100 : 4'b0011);
      2'b10:   lane_mask = (offset == 2'b00) ? 4'b1111 : 4'b0000;
      default: lane_mask = 4'b0000;
    endcase
  end

  always_comb begin
    dmem_req.addr  = {addr[rv_pkg::xlen-1:2], 2'b00};
    dmem_req.read  = ctrl.mem_read;
    dmem_req.write = ctrl.mem_write;
    dmem_req.wmask = ctrl.mem_write ? lane_mask : 4'b0000;
    case (ctrl.mem_size[1:0])
      2'b00:   dmem_req.wdata = {4{store_data[7:0]}};  // same byte on every lane
      2'b01:   dmem_req.wdata = {2{store_data[15:0]}};
      default: dmem_req.wdata = store_data;
    endcase

    assert (!(dmem_req.read && dmem_req.write))
      else $error("lsu: load and store decoded together");
    // an empty mask on a store means the access was misaligned
    assert (!dmem_req.write || (dmem_req.wmask != 4'b0000))
      else $error("lsu: write mask does not match the request");
  end

  assign lane_word = dmem_rdata >> {offset, 3'b000};

  always_comb begin
    case (ctrl.mem_size)
      3'b000:  load_data = {{24{lane_word[7]}}, lane_word[7:0]};    // lb
      3'b001:  load_data = {{16{lane_word[15]}}, lane_word[15:0]};  // lh
      3'b100:  load_data = {24'h000000, lane_word[7:0]};            // lbu
      3'b101:  load_data = {16'h0000, lane_word[15:0]};             // lhu
      default: load_data = dmem_rdata;                              // lw
    endcase
  end

endmodule

/* source/rv_top.sv */
`timescale 1ns/1ps

module rv_top #(
  parameter logic [rv_pkg::xlen-1:0] RESET_PC = 32'h0000_0000
) (
  input  logic                    clk,
  input  logic                    arst_n,
  output logic [rv_pkg::xlen-1:0] imem_addr,
  input  logic [rv_pkg::xlen-1:0] imem_rdata,
  output rv_pkg::dmem_req_t       dmem_req,
  input  logic [rv_pkg::xlen-1:0] dmem_rdata,
  output logic                    halted
);

  logic [rv_pkg::xlen-1:0] pc;
  logic [rv_pkg::xlen-1:0] pc_next;
  logic [rv_pkg::xlen-1:0] pc_plus4;
  logic [rv_pkg::xlen-1:0] jump_base;
  logic [rv_pkg::xlen-1:0] jump_sum;
  logic [rv_pkg::xlen-1:0] jump_target;
  logic [rv_pkg::xlen-1:0] rs1_data;
  logic [rv_pkg::xlen-1:0] rs2_data;
  logic [rv_pkg::xlen-1:0] alu_result;
  logic [rv_pkg::xlen-1:0] load_data;
  logic [rv_pkg::xlen-1:0] wb_data;
  logic                    take_branch;
  logic                    reg_we;
  rv_pkg::inst_t           inst;
  rv_pkg::ctrl_t           ctrl;
  rv_pkg::dmem_req_t       lsu_req;

  assign imem_addr = pc;
  assign inst      = imem_rdata;

  rv_decoder decoder_i (
    .inst (inst),
    .ctrl (ctrl)
  );

  rv_regfile regfile_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (reg_we),
    .rd       (ctrl.rd),
    .wdata    (wb_data)
  );

  rv_alu alu_i (
    .ctrl        (ctrl),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .result      (alu_result),
    .take_branch (take_branch)
  );

  rv_lsu lsu_i (
    .ctrl       (ctrl),
    .addr       (alu_result),
    .store_data (rs2_data),
    .dmem_req   (lsu_req),
    .dmem_rdata (dmem_rdata),
    .load_data  (load_data)
  );

  // shared adder, branch/jal/auipc off pc, jalr off rs1
  assign pc_plus4    = pc + 32'd4;
  assign jump_base   = ctrl.is_jalr ? rs1_data : pc;
  assign jump_sum    = jump_base + ctrl.imm;
  assign jump_target = ctrl.is_jalr ? {jump_sum[rv_pkg::xlen-1:1], 1'b0} : jump_sum;

  always_comb begin
    if (halted || ctrl.halt) begin
      pc_next = pc;                     // stay on the ebreak
    end else if (ctrl.is_jal || ctrl.is_jalr || take_branch) begin
      pc_next = jump_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_comb begin
    case (ctrl.wb_sel)
      rv_pkg::wb_mem:       wb_data = load_data;
      rv_pkg::wb_link:      wb_data = pc_plus4;
      rv_pkg::wb_imm:       wb_data = ctrl.imm;
      rv_pkg::wb_pc_target: wb_data = jump_target;
      default:              wb_data = alu_result;
    endcase
  end

  // nothing leaves the core once halted
  assign reg_we = ctrl.reg_write && !halted;

  always_comb begin
    dmem_req       = lsu_req;
    dmem_req.write = lsu_req.write && !halted;
    dmem_req.wmask = halted ? 4'b0000 : lsu_req.wmask;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc     <= RESET_PC;
      halted <= 1'b0;
    end else begin
      pc <= pc_next;
      if (ctrl.halt) begin
        halted <= 1'b1;
      end
    end
  end

  // jalr clears bit 0 only, so a bad rs1 or offset shows up here
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00
  );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;  // release on a rising edge
  end

endmodule

/* sim/rv_top_tb.sv */
`timescale 1ns/1ps

module rv_top_tb;

  localparam int CLK_PERIOD      = 4;
  localparam int MEM_WORDS       = 2048;  // 8 KiB, code low, data at 0x1000
  localparam int CYCLES_PER_WORD = 64;

  logic              clk;
  logic              arst_n;
  logic [31:0]       imem_addr;
  logic [31:0]       imem_rdata;
  logic [31:0]       dmem_rdata;
  rv_pkg::dmem_req_t dmem_req;
  logic              halted;

  logic [31:0] mem [0:MEM_WORDS-1];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [3:0]  exp_mask [$];
  logic [31:0] halt_pc = '0;
  int          prog_words = 0;
  int          store_idx = 0;

  tb_clock #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (4)
  ) clock_i (
    .clk    (clk),
    .arst_n (arst_n)
  );

  rv_top #(
    .RESET_PC (32'h0000_0000)
  ) rv_top_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .dmem_req   (dmem_req),
    .dmem_rdata (dmem_rdata),
    .halted     (halted)
  );

  // both ports answer in the same cycle
  assign imem_rdata = mem[imem_addr[12:2]];
  assign dmem_rdata = dmem_req.read ? mem[dmem_req.addr[12:2]] : 32'h0000_0000;

  task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                             input string what);
    if (got !== expected) begin
      $display("Error at %0d ns: %s is %08h, expected %08h", $time, what, got, expected);
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // tags I (word addr, instruction), S (addr, data, mask) and H (halt pc)
  task automatic load_program_file();
    int          fd;
    int          n;
    string       line;
    byte         tag;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = i * 32'h9e37_79b1;  // scrambled by the full address
    end
    fd = $fopen("sim/golden_program.hex", "r");
    if (fd == 0) begin
      $display("could not open sim/golden_program.hex");
      $display("Checks failed");
      $fatal(1, "missing stimulus file");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line[0] == "#") continue;
      a = '0;
      b = '0;
      c = '0;
      n = $sscanf(line, "%c %h %h %h", tag, a, b, c);
      case (tag)
        "I": begin
          mem[a[10:0]] = b;
          prog_words++;
        end
        "S": begin
          exp_addr.push_back(a);
          exp_data.push_back(b);
          exp_mask.push_back(c[3:0]);
        end
        "H": halt_pc = a;
        default: ;
      endcase
    end
    $fclose(fd);
    if (prog_words == 0) begin
      $display("the stimulus file holds no program words");
      $display("Checks failed");
      $fatal(1, "empty program");
    end
  endtask

  // request is sampled before the edge moves the pc
  always @(posedge clk) begin
    if (arst_n && dmem_req.write) begin
      if (store_idx >= exp_addr.size()) begin
        $display("unexpected store of %08h to %08h after the last expected one",
                 dmem_req.wdata, dmem_req.addr);
        $display("Checks failed");
        $fatal(1, "extra store");
      end else begin
        check_value(dmem_req.addr, exp_addr[store_idx], "store address");
        check_value(dmem_req.wdata, exp_data[store_idx], "store data");
        check_value({28'h0, dmem_req.wmask}, {28'h0, exp_mask[store_idx]}, "store mask");
        for (int l = 0; l < 4; l++) begin
          if (dmem_req.wmask[l]) begin
            mem[dmem_req.addr[12:2]][8*l +: 8] <= dmem_req.wdata[8*l +: 8];
          end
        end
        store_idx++;
      end
    end
  end

  // watchdog scaled by program length
  initial begin
    wait (prog_words > 0);
    #(prog_words * CYCLES_PER_WORD * CLK_PERIOD);
    $display("watchdog expired, the core never halted");
    $display("Checks failed");
    $fatal(1, "timeout");
  end

  initial begin
    load_program_file();
    wait (halted === 1'b1);
    repeat (4) @(negedge clk);  // pc must hold after ebreak
    check_value(imem_addr, halt_pc, "halt pc");
    check_value({31'b0, halted}, 32'd1, "halted flag");
    if (store_idx != exp_addr.size()) begin
      $display("only %0d of %0d expected stores were seen", store_idx, exp_addr.size());
      $display("Checks failed");
      $fatal(1, "missing stores");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

/* project.f */
common/rv_pkg.sv
core/rv_decoder.sv
core/rv_regfile.sv
core/rv_alu.sv
core/rv_lsu.sv
source/rv_top.sv
sim/tb_clock.sv
sim/rv_top_tb.sv

/* run.sh */
#!/bin/sh
# build and run the rv_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module rv_top_tb \
  -f project.f \
  --Mdir obj_dir \
  -o rv_top_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit $status
fi

./obj_dir/rv_top_tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi
exit 0

/* sim/golden_program.hex */
# I <word addr> <instruction> | S <byte addr> <data> <mask> | H <halt pc>
# x1 = 0x1000 data base, x2 = -7, x3 = 5
I 000 000010B7
I 001 FF900113
I 002 00500193
I 003 00310233
I 004 402182B3
I 005 00312333
I 006 003133B3
I 007 40115413
I 008 0F01C493
I 009 00419513
I 00A 003155B3
I 00B 0024F633
I 00C 0010A023
I 00D 0040A223
I 00E 0050A423
I 00F 0060A623
I 010 0070A823
I 011 0080AA23
I 012 0090AC23
I 013 00A0AE23
I 014 02B0A023
I 015 02C0A223
# sub-word stores to 0x1040, then lw and store back
I 016 04809023
I 017 04909123
I 018 049080A3
I 019 049081A3
I 01A 04308023
I 01B 0400A683
I 01C 02D0A423
I 01D 04108703
I 01E 0420C783
I 01F 04209803
I 020 0400D883
I 021 02E0A623
I 022 02F0A823
I 023 0300AA23
I 024 0310AC23
# branch pairs, not taken then taken, each skips one ori
I 025 00310463
I 026 001A6A13
I 027 00318463
I 028 040A6A13
I 029 00319463
I 02A 002A6A13
I 02B 00311463
I 02C 080A6A13
I 02D 0021C463
I 02E 004A6A13
I 02F 00314463
I 030 100A6A13
I 031 00315463
I 032 008A6A13
I 033 0021D463
I 034 200A6A13
I 035 00316463
I 036 010A6A13
I 037 0021E463
I 038 400A6A13
I 039 0021F463
I 03A 020A6A13
I 03B 00317463
I 03C 600A6A13
I 03D 0340AE23
# jal, auipc, jalr with odd offset, then ebreak
I 03E 00800AEF
I 03F 00000A93
I 040 00000B97
I 041 00DB8C67
I 042 00000C13
I 043 0550A223
I 044 0570A423
I 045 0580A623
I 046 00100073
I 047 0010A023
S 00001000 00001000 F
S 00001004 FFFFFFFE F
S 00001008 0000000C F
S 0000100C 00000001 F
S 00001010 00000000 F
S 00001014 FFFFFFFC F
S 00001018 000000F5 F
S 0000101C 00000050 F
S 00001020 07FFFFFF F
S 00001024 000000F1 F
S 00001040 FFFCFFFC 3
S 00001040 00F500F5 C
S 00001040 F5F5F5F5 2
S 00001040 F5F5F5F5 8
S 00001040 05050505 1
S 00001028 F5F5F505 F
S 0000102C FFFFFFF5 F
S 00001030 000000F5 F
S 00001034 FFFFF5F5 F
S 00001038 0000F505 F
S 0000103C 0000003F F
S 00001044 000000FC F
S 00001048 00000100 F
S 0000104C 00000108 F
H 00000118
